// File: cnn_pkg.sv
package cnn_pkg;

	// ------------------------------
	// Widths
	// ------------------------------
	localparam int PIX_W     = 8;   // Pixel / activation
	localparam int NUM_KERN  = 4;   // Output channels
	localparam int NUM_TAPS  = 9;   // 3x3 window
	localparam int DIM_W     = 8;   // Width, height, row, col
	localparam int DELAY_W   = 12;  // Start-up and row-gap counters
	localparam int ACC_W     = 20;  // 9 taps of u8 x s8
	localparam int POST_W    = 48;  // Scale, bias and shift path
	localparam int REG_IDX_W = 4;

	// Register word indices, byte address bits 5..2
	localparam logic [REG_IDX_W-1:0] REG_WIDTH_HEIGHT = 4'd0;
	localparam logic [REG_IDX_W-1:0] REG_DELAYS       = 4'd1;
	localparam logic [REG_IDX_W-1:0] REG_LAYER_CFG    = 4'd2;
	localparam logic [REG_IDX_W-1:0] REG_IMG_ADDR     = 4'd3;
	localparam logic [REG_IDX_W-1:0] REG_IMG_DATA     = 4'd4;
	localparam logic [REG_IDX_W-1:0] REG_WEIGHT       = 4'd5;
	localparam logic [REG_IDX_W-1:0] REG_PARAM        = 4'd6;
	localparam logic [REG_IDX_W-1:0] REG_LAYER_START  = 4'd7;
	localparam logic [REG_IDX_W-1:0] REG_LAYER_DONE   = 4'd8;

	// AHB codes
	localparam logic [1:0] TRANS_IDLE   = 2'b00;
	localparam logic [1:0] TRANS_NONSEQ = 2'b10;
	localparam logic [1:0] TRANS_SEQ    = 2'b11;
	localparam logic [1:0] RESP_OKAY    = 2'b00;

	// ------------------------------
	// Block to block bundles
	// ------------------------------
	typedef struct packed {
		logic       act_type;    // 0 ReLU, 1 linear
		logic [4:0] bias_shift;
		logic [2:0] act_shift;
	} layer_cfg_t;

	typedef struct packed {
		logic [DIM_W-1:0]   width;
		logic [DIM_W-1:0]   height;
		logic [DELAY_W-1:0] start_up_delay;
		logic [DELAY_W-1:0] hsync_delay;
	} frame_cfg_t;

	typedef struct packed {
		logic             valid;
		logic [DIM_W-1:0] row;
		logic [DIM_W-1:0] col;
		logic             first_row;
		logic             last_row;
		logic             first_col;
		logic             last_col;
	} scan_pos_t;

	typedef struct packed {
		logic                          valid;
		logic [NUM_TAPS-1:0][PIX_W-1:0] pix; // pix[0] top-left, raster order
	} window_t;

	typedef struct packed {
		logic        strobe;
		logic [1:0]  kern;
		logic [3:0]  tap;
		logic [15:0] value;     // {scale, bias} or {8'h0, weight}
		logic        is_param;
	} coef_wr_t;

	// Bus word, one layout per register
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [15:0] height;
			logic [15:0] width;
		} dims;
		struct packed {
			logic [7:0]  rsvd;
			logic [11:0] hsync;
			logic [11:0] start_up;
		} delays;
		struct packed {
			logic [15:0] rsvd_hi;
			logic [2:0]  act_shift;
			logic [4:0]  bias_shift;
			logic [3:0]  rsvd_mid;
			logic        act_type;
			logic [2:0]  rsvd_lo;
		} cfg;
		struct packed {
			logic [17:0]       rsvd;
			logic [1:0]        kern;
			logic [3:0]        tap;
			logic signed [7:0] weight;
		} weight;
		struct packed {
			logic [13:0]       rsvd;
			logic [1:0]        kern;
			logic signed [7:0] scale;
			logic signed [7:0] bias;
		} param;
	} reg_word_u;

endpackage

// File: cnn_ahb_regs.sv
`timescale 1ns/1ns
module cnn_ahb_regs #(
	parameter int MAX_PIXELS   = 256,
	parameter int DEF_WIDTH    = 8,
	parameter int DEF_HEIGHT   = 8,
	parameter int DEF_START_UP = 20,
	parameter int DEF_HSYNC    = 4
) (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            sl_hsel_i,
	input  logic                            sl_hready_i,
	input  logic [1:0]                      sl_htrans_i,
	input  logic [31:0]                     sl_haddr_i,
	input  logic                            sl_hwrite_i,
	input  logic [31:0]                     sl_hwdata_i,
	input  logic                            layer_done_i,
	output logic                            sl_hready_o,
	output logic [1:0]                      sl_hresp_o,
	output logic [31:0]                     sl_hrdata_o,
	output cnn_pkg::frame_cfg_t             frame_cfg_o,
	output cnn_pkg::layer_cfg_t             layer_cfg_o,
	output logic                            start_o,
	output logic                            img_we_o,
	output logic [$clog2(MAX_PIXELS)-1:0]   img_addr_o,
	output logic [cnn_pkg::PIX_W-1:0]       img_data_o,
	output cnn_pkg::coef_wr_t               coef_wr_o
);
	import cnn_pkg::*;

	localparam int AW = $clog2(MAX_PIXELS);

	logic [REG_IDX_W-1:0] sel_q;   // Latched word index
	logic                 wr_q;    // Data-phase write pending
	logic                 accept;
	frame_cfg_t           frame_q;
	layer_cfg_t           layer_q;
	logic [AW-1:0]        img_addr_q;
	reg_word_u            wr_word;
	reg_word_u            rd_word;

	assign accept = sl_hsel_i && sl_hready_i &&
		(sl_htrans_i == TRANS_NONSEQ || sl_htrans_i == TRANS_SEQ);
	assign wr_word.raw = sl_hwdata_i;

	// ------------------------------
	// Address phase
	// ------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			sel_q <= '0;
			wr_q  <= 1'b0;
		end else if (accept) begin
			sel_q <= sl_haddr_i[REG_IDX_W+1:2];
			wr_q  <= sl_hwrite_i;
		end else begin
			wr_q  <= 1'b0;   // Idle or busy slot
		end
	end

	// ------------------------------
	// Data phase, config writes
	// ------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			frame_q.width          <= DIM_W'(DEF_WIDTH);
			frame_q.height         <= DIM_W'(DEF_HEIGHT);
			frame_q.start_up_delay <= DELAY_W'(DEF_START_UP);
			frame_q.hsync_delay    <= DELAY_W'(DEF_HSYNC);
			layer_q                <= '0;   // ReLU, no shifts
			img_addr_q             <= '0;
		end else if (wr_q) begin
			case (sel_q)
				REG_WIDTH_HEIGHT: begin
					frame_q.width  <= wr_word.dims.width[DIM_W-1:0];
					frame_q.height <= wr_word.dims.height[DIM_W-1:0];
				end
				REG_DELAYS: begin
					frame_q.start_up_delay <= wr_word.delays.start_up;
					frame_q.hsync_delay    <= wr_word.delays.hsync;
				end
				REG_LAYER_CFG: begin
					layer_q.act_type   <= wr_word.cfg.act_type;
					layer_q.bias_shift <= wr_word.cfg.bias_shift;
					layer_q.act_shift  <= wr_word.cfg.act_shift;
				end
				REG_IMG_ADDR: img_addr_q <= wr_word.raw[AW-1:0];
				REG_IMG_DATA: img_addr_q <= img_addr_q + 1'b1;  // Auto increment
				default: ;
			endcase
		end
	end

	// Strobes live in the data phase only
	assign start_o    = wr_q && (sel_q == REG_LAYER_START) && wr_word.raw[0];
	assign img_we_o   = wr_q && (sel_q == REG_IMG_DATA);
	assign img_addr_o = img_addr_q;
	assign img_data_o = wr_word.raw[PIX_W-1:0];

	always_comb begin
		coef_wr_o          = '0;
		coef_wr_o.strobe   = wr_q && (sel_q == REG_WEIGHT || sel_q == REG_PARAM);
		coef_wr_o.is_param = (sel_q == REG_PARAM);
		if (coef_wr_o.is_param) begin
			coef_wr_o.kern  = wr_word.param.kern;
			coef_wr_o.value = {wr_word.param.scale, wr_word.param.bias};
		end else begin
			coef_wr_o.kern  = wr_word.weight.kern;
			coef_wr_o.tap   = wr_word.weight.tap;
			coef_wr_o.value = {8'h00, wr_word.weight.weight};
		end
	end

	// Readback in the write layouts
	always_comb begin
		rd_word = '0;
		case (sel_q)
			REG_WIDTH_HEIGHT: begin
				rd_word.dims.width  = 16'(frame_q.width);
				rd_word.dims.height = 16'(frame_q.height);
			end
			REG_DELAYS: begin
				rd_word.delays.start_up = frame_q.start_up_delay;
				rd_word.delays.hsync    = frame_q.hsync_delay;
			end
			REG_LAYER_CFG: begin
				rd_word.cfg.act_type   = layer_q.act_type;
				rd_word.cfg.bias_shift = layer_q.bias_shift;
				rd_word.cfg.act_shift  = layer_q.act_shift;
			end
			REG_IMG_ADDR:   rd_word.raw = 32'(img_addr_q);
			REG_LAYER_DONE: rd_word.raw = {31'b0, layer_done_i};
			default: ;     // Write-only words read 0
		endcase
	end

	assign sl_hrdata_o = rd_word.raw;
	assign sl_hready_o = 1'b1;         // Zero wait states
	assign sl_hresp_o  = RESP_OKAY;
	assign frame_cfg_o = frame_q;
	assign layer_cfg_o = layer_q;

	// Accepted writes only ever target the decoded map
	a_wr_idx: assert property (@(posedge clk) disable iff (!rstn)
		accept && sl_hwrite_i |=> sel_q <= REG_LAYER_DONE);

endmodule

// File: frame_scan.sv
`timescale 1ns/1ns
module frame_scan (
	input  logic                clk,
	input  logic                rstn,
	input  cnn_pkg::frame_cfg_t frame_cfg_i,
	input  logic                start_i,
	output cnn_pkg::scan_pos_t  pos_o,
	output logic                frame_end_o
);
	import cnn_pkg::*;

	localparam logic [1:0] ST_WAIT = 2'd0;  // Start-up delay
	localparam logic [1:0] ST_ROW  = 2'd1;  // Emitting positions
	localparam logic [1:0] ST_GAP  = 2'd2;  // Idle between rows

	logic [1:0]         state_q;
	logic               busy_q;
	logic [DELAY_W-1:0] dly_q;
	logic [DELAY_W-1:0] dly_lim;
	logic [DIM_W-1:0]   row_q;
	logic [DIM_W-1:0]   col_q;
	logic               end_q;
	logic               last_row;
	logic               last_col;

	assign last_row = (row_q == frame_cfg_i.height - 1'b1);
	assign last_col = (col_q == frame_cfg_i.width - 1'b1);
	assign dly_lim  = (state_q == ST_WAIT) ? frame_cfg_i.start_up_delay
	                                       : frame_cfg_i.hsync_delay;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= ST_WAIT;
			busy_q  <= 1'b0;
			dly_q   <= '0;
			row_q   <= '0;
			col_q   <= '0;
			end_q   <= 1'b0;
		end else begin
			end_q <= 1'b0;
			if (start_i) begin           // Also restarts a running scan
				state_q <= ST_WAIT;
				busy_q  <= 1'b1;
				dly_q   <= DELAY_W'(1);
				row_q   <= '0;
				col_q   <= '0;
			end else if (busy_q) begin
				case (state_q)
					ST_ROW: begin
						if (last_col) begin
							col_q <= '0;
							if (last_row) begin
								busy_q <= 1'b0;
								end_q  <= 1'b1;  // Frame end next cycle
							end else begin
								row_q   <= row_q + 1'b1;
								state_q <= ST_GAP;
								dly_q   <= DELAY_W'(1);
							end
						end else begin
							col_q <= col_q + 1'b1;
						end
					end
					default: begin           // Wait and gap share the counter
						if (dly_q >= dly_lim)
							state_q <= ST_ROW;
						else
							dly_q <= dly_q + 1'b1;
					end
				endcase
			end
		end
	end

	assign pos_o.valid     = busy_q && (state_q == ST_ROW);
	assign pos_o.row       = row_q;
	assign pos_o.col       = col_q;
	assign pos_o.first_row = (row_q == '0);
	assign pos_o.last_row  = last_row;
	assign pos_o.first_col = (col_q == '0);
	assign pos_o.last_col  = last_col;
	assign frame_end_o     = end_q;

	a_pos_in_frame: assert property (@(posedge clk) disable iff (!rstn)
		pos_o.valid |-> (pos_o.col < frame_cfg_i.width) && (pos_o.row < frame_cfg_i.height));

endmodule

// File: image_buffer.sv
`timescale 1ns/1ns
module image_buffer #(
	parameter int MAX_PIXELS = 256
) (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          img_we_i,
	input  logic [$clog2(MAX_PIXELS)-1:0] img_addr_i,
	input  logic [cnn_pkg::PIX_W-1:0]     img_data_i,
	input  cnn_pkg::frame_cfg_t           frame_cfg_i,
	input  cnn_pkg::scan_pos_t            pos_i,
	output cnn_pkg::window_t              win_o
);
	import cnn_pkg::*;

	localparam int AW = $clog2(MAX_PIXELS);

	logic [PIX_W-1:0]               mem [MAX_PIXELS];
	logic [AW-1:0]                  center;
	logic [AW-1:0]                  nb_addr;
	logic                           outside;
	logic [NUM_TAPS-1:0][PIX_W-1:0] taps;
	logic                           valid_q;
	logic [NUM_TAPS-1:0][PIX_W-1:0] pix_q;

	// Frame memory, raster order
	always_ff @(posedge clk) begin
		if (img_we_i)
			mem[img_addr_i] <= img_data_i;
	end

	assign center = AW'(pos_i.row * frame_cfg_i.width + pos_i.col);

	// Nine neighbours, zero outside the image
	always_comb begin
		taps = '0;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				nb_addr = center + AW'(r * frame_cfg_i.width) - AW'(frame_cfg_i.width)
				        + AW'(c) - AW'(1);
				outside = (r == 0 && pos_i.first_row) || (r == 2 && pos_i.last_row) ||
				          (c == 0 && pos_i.first_col) || (c == 2 && pos_i.last_col);
				if (!outside)
					taps[r*3+c] = mem[nb_addr];
			end
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			valid_q <= 1'b0;
		else
			valid_q <= pos_i.valid;  // One cycle latency
	end

	always_ff @(posedge clk) begin
		if (pos_i.valid)
			pix_q <= taps;
	end

	assign win_o.valid = valid_q;
	assign win_o.pix   = pix_q;

endmodule

// File: conv_kernel.sv
`timescale 1ns/1ns
module conv_kernel (
	input  logic                                            clk,
	input  logic                                            rstn,
	input  cnn_pkg::layer_cfg_t                             layer_cfg_i,
	input  logic [cnn_pkg::NUM_TAPS-1:0][cnn_pkg::PIX_W-1:0] weights_i,
	input  logic signed [cnn_pkg::PIX_W-1:0]                scale_i,
	input  logic signed [cnn_pkg::PIX_W-1:0]                bias_i,
	input  cnn_pkg::window_t                                win_i,
	output logic [cnn_pkg::PIX_W-1:0]                       act_o,
	output logic                                            vld_o
);
	import cnn_pkg::*;

	logic signed [ACC_W-1:0]  prod;
	logic signed [ACC_W-1:0]  sum;
	logic signed [ACC_W-1:0]  acc_q;
	logic                     vld1_q;
	logic signed [POST_W-1:0] scaled;
	logic signed [POST_W-1:0] bias_ext;
	logic signed [POST_W-1:0] post;
	logic [PIX_W-1:0]         act_d;
	logic [PIX_W-1:0]         act_q;
	logic                     vld2_q;

	// ------------------------------
	// Stage 1, 9-tap MAC
	// ------------------------------
	always_comb begin
		sum = '0;
		for (int t = 0; t < NUM_TAPS; t++) begin
			prod = $signed(weights_i[t]) * $signed({1'b0, win_i.pix[t]}); // Pixel unsigned
			sum  = sum + prod;
		end
	end

	// ------------------------------
	// Stage 2, scale, bias, activation
	// ------------------------------
	always_comb begin
		scaled   = acc_q * scale_i;
		bias_ext = bias_i;
		post     = (scaled + (bias_ext <<< layer_cfg_i.bias_shift)) >>> layer_cfg_i.act_shift;
		if (!layer_cfg_i.act_type) begin      // ReLU, clamp 0..255
			if (post < 0)
				act_d = '0;
			else if (post > 255)
				act_d = 8'd255;
			else
				act_d = post[PIX_W-1:0];
		end else begin                        // Linear, clamp -128..127
			if (post < -128)
				act_d = 8'h80;
			else if (post > 127)
				act_d = 8'h7f;
			else
				act_d = post[PIX_W-1:0];
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			vld1_q <= 1'b0;
			vld2_q <= 1'b0;
		end else begin
			vld1_q <= win_i.valid;
			vld2_q <= vld1_q;
		end
	end

	always_ff @(posedge clk) begin
		acc_q <= sum;
		act_q <= act_d;
	end

	assign act_o = act_q;
	assign vld_o = vld2_q;

endmodule

// File: conv_array.sv
`timescale 1ns/1ns
module conv_array (
	input  logic                                          clk,
	input  logic                                          rstn,
	input  cnn_pkg::coef_wr_t                             coef_wr_i,
	input  cnn_pkg::layer_cfg_t                           layer_cfg_i,
	input  cnn_pkg::frame_cfg_t                           frame_cfg_i,
	input  logic                                          start_i,
	input  cnn_pkg::window_t                              win_i,
	output logic [cnn_pkg::NUM_KERN*cnn_pkg::PIX_W-1:0]   out_pixel_o,
	output logic                                          out_valid_o,
	output logic                                          layer_done_o
);
	import cnn_pkg::*;

	logic [NUM_KERN-1:0][NUM_TAPS-1:0][PIX_W-1:0] weight_q;
	logic [NUM_KERN-1:0][PIX_W-1:0]               scale_q;
	logic [NUM_KERN-1:0][PIX_W-1:0]               bias_q;
	logic [NUM_KERN-1:0][PIX_W-1:0]               act;    // act[k] lands at 8k+7..8k
	logic [NUM_KERN-1:0]                          vld;
	logic [2*DIM_W-1:0]                           frame_px;
	logic [2*DIM_W-1:0]                           out_cnt_q;
	logic                                         done_q;

	// ------------------------------
	// Coefficient store
	// ------------------------------
	always_ff @(posedge clk) begin
		if (coef_wr_i.strobe) begin
			if (coef_wr_i.is_param) begin
				scale_q[coef_wr_i.kern] <= coef_wr_i.value[15:8];
				bias_q[coef_wr_i.kern]  <= coef_wr_i.value[7:0];
			end else if (coef_wr_i.tap < NUM_TAPS) begin  // Taps 9..15 dropped
				weight_q[coef_wr_i.kern][coef_wr_i.tap] <= coef_wr_i.value[7:0];
			end
		end
	end

	for (genvar k = 0; k < NUM_KERN; k++) begin : g_kern
		conv_kernel u_kern (
			.clk         (clk),
			.rstn        (rstn),
			.layer_cfg_i (layer_cfg_i),
			.weights_i   (weight_q[k]),
			.scale_i     (scale_q[k]),
			.bias_i      (bias_q[k]),
			.win_i       (win_i),
			.act_o       (act[k]),
			.vld_o       (vld[k])
		);
	end

	// ------------------------------
	// Output count and layer done
	// ------------------------------
	assign frame_px = frame_cfg_i.width * frame_cfg_i.height;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			out_cnt_q <= '0;
			done_q    <= 1'b0;
		end else if (start_i) begin
			out_cnt_q <= '0;
			done_q    <= 1'b0;
		end else if (vld[0]) begin
			if (out_cnt_q == frame_px - 1'b1) begin
				out_cnt_q <= '0;
				done_q    <= 1'b1;
			end else begin
				out_cnt_q <= out_cnt_q + 1'b1;
			end
		end
	end

	assign out_pixel_o  = act;
	assign out_valid_o  = vld[0];   // All channels in lockstep
	assign layer_done_o = done_q;

	a_vld_lockstep: assert property (@(posedge clk) disable iff (!rstn)
		(vld == '0) || (&vld));

endmodule

// File: cnn_accel.sv
`timescale 1ns/1ns
module cnn_accel #(
	parameter int MAX_PIXELS   = 256,
	parameter int DEF_WIDTH    = 8,
	parameter int DEF_HEIGHT   = 8,
	parameter int DEF_START_UP = 20,
	parameter int DEF_HSYNC    = 4
) (
	input  logic                                        clk,
	input  logic                                        rstn,
	input  logic                                        sl_hsel_i,
	input  logic                                        sl_hready_i,
	input  logic [1:0]                                  sl_htrans_i,
	input  logic [31:0]                                 sl_haddr_i,
	input  logic                                        sl_hwrite_i,
	input  logic [31:0]                                 sl_hwdata_i,
	output logic                                        out_sl_hready_o,
	output logic [1:0]                                  out_sl_hresp_o,
	output logic [31:0]                                 out_sl_hrdata_o,
	output logic [cnn_pkg::NUM_KERN*cnn_pkg::PIX_W-1:0] out_pixel_o,
	output logic                                        out_valid_o
);
	import cnn_pkg::*;

	frame_cfg_t                    frame_cfg;
	layer_cfg_t                    layer_cfg;
	coef_wr_t                      coef_wr;
	scan_pos_t                     pos;
	window_t                       win;
	logic                          start;
	logic                          layer_done;
	logic                          img_we;
	logic [$clog2(MAX_PIXELS)-1:0] img_addr;
	logic [PIX_W-1:0]              img_data;

	// Bus registers, the controller
	cnn_ahb_regs #(
		.MAX_PIXELS   (MAX_PIXELS),
		.DEF_WIDTH    (DEF_WIDTH),
		.DEF_HEIGHT   (DEF_HEIGHT),
		.DEF_START_UP (DEF_START_UP),
		.DEF_HSYNC    (DEF_HSYNC)
	) u_regs (
		.clk          (clk),
		.rstn         (rstn),
		.sl_hsel_i    (sl_hsel_i),
		.sl_hready_i  (sl_hready_i),
		.sl_htrans_i  (sl_htrans_i),
		.sl_haddr_i   (sl_haddr_i),
		.sl_hwrite_i  (sl_hwrite_i),
		.sl_hwdata_i  (sl_hwdata_i),
		.layer_done_i (layer_done),
		.sl_hready_o  (out_sl_hready_o),
		.sl_hresp_o   (out_sl_hresp_o),
		.sl_hrdata_o  (out_sl_hrdata_o),
		.frame_cfg_o  (frame_cfg),
		.layer_cfg_o  (layer_cfg),
		.start_o      (start),
		.img_we_o     (img_we),
		.img_addr_o   (img_addr),
		.img_data_o   (img_data),
		.coef_wr_o    (coef_wr)
	);

	frame_scan u_scan (
		.clk         (clk),
		.rstn        (rstn),
		.frame_cfg_i (frame_cfg),
		.start_i     (start),
		.pos_o       (pos),
		.frame_end_o ()           // Frame end tracked by the output count
	);

	image_buffer #(.MAX_PIXELS(MAX_PIXELS)) u_buf (
		.clk         (clk),
		.rstn        (rstn),
		.img_we_i    (img_we),
		.img_addr_i  (img_addr),
		.img_data_i  (img_data),
		.frame_cfg_i (frame_cfg),
		.pos_i       (pos),
		.win_o       (win)
	);

	conv_array u_array (
		.clk          (clk),
		.rstn         (rstn),
		.coef_wr_i    (coef_wr),
		.layer_cfg_i  (layer_cfg),
		.frame_cfg_i  (frame_cfg),
		.start_i      (start),
		.win_i        (win),
		.out_pixel_o  (out_pixel_o),
		.out_valid_o  (out_valid_o),
		.layer_done_o (layer_done)
	);

endmodule

// File: tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ------------------------------
// Testbench copy of frame and layer
// ------------------------------
logic [7:0]        img [256];     // Raster order, row * width + col
logic signed [7:0] wt  [4][9];    // Tap 0 top-left
logic signed [7:0] sc  [4];
logic signed [7:0] bi  [4];
int                cur_w;
int                cur_h;
bit                cur_act;       // 0 ReLU, 1 linear
int                cur_bs;
int                cur_as;

// Expected activation of kernel k at one pixel
function automatic logic [7:0] ref_act(input int row, input int col, input int k);
	longint acc;
	longint post;
	int     rr;
	int     cc;
	acc = 0;
	for (int t = 0; t < 9; t++) begin
		rr = row + t / 3 - 1;
		cc = col + t % 3 - 1;
		if (rr >= 0 && rr < cur_h && cc >= 0 && cc < cur_w)   // Padding taps add nothing
			acc += longint'(wt[k][t]) * longint'(img[rr * cur_w + cc]);
	end
	post = (acc * longint'(sc[k]) + (longint'(bi[k]) <<< cur_bs)) >>> cur_as;
	if (!cur_act) begin
		if (post < 0)
			return 8'd0;
		if (post > 255)
			return 8'd255;
	end else begin
		if (post < -128)
			return 8'h80;
		if (post > 127)
			return 8'h7f;
	end
	return post[7:0];   // Two's complement in linear mode
endfunction

`endif

// File: tb_cnn_accel.sv
`timescale 1ns/1ns
module tb_cnn_accel;
	import cnn_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int SU         = 6;    // Start-up delay used by every frame
	localparam int HS         = 3;    // Row gap
	localparam int QUIET      = 20;   // Cycles watched for stray outputs
	localparam int NUM_FRAMES = 5;
	localparam int FR_W [NUM_FRAMES] = '{8, 6, 7, 5, 3};
	localparam int FR_H [NUM_FRAMES] = '{8, 5, 4, 3, 6};

	logic        clk;
	logic        rstn;
	logic        hsel;
	logic        hready_in;
	logic [1:0]  htrans;
	logic [31:0] haddr;
	logic        hwrite;
	logic [31:0] hwdata;
	logic        hready;
	logic [1:0]  hresp;
	logic [31:0] hrdata;
	logic [31:0] out_pixel;
	logic        out_valid;

	logic [31:0] exp_q [$];          // Expected pixels, raster order
	logic [31:0] got_pix [256];
	logic [31:0] exp_pix;
	int          pulse_cnt;
	int          err_cnt;
	int          seed;
	string       cur_test;

	`include "tb_ref_model.svh"

	cnn_accel i_dut (
		.clk             (clk),
		.rstn            (rstn),
		.sl_hsel_i       (hsel),
		.sl_hready_i     (hready_in),
		.sl_htrans_i     (htrans),
		.sl_haddr_i      (haddr),
		.sl_hwrite_i     (hwrite),
		.sl_hwdata_i     (hwdata),
		.out_sl_hready_o (hready),
		.out_sl_hresp_o  (hresp),
		.out_sl_hrdata_o (hrdata),
		.out_pixel_o     (out_pixel),
		.out_valid_o     (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------
	// Failure and compare helpers
	// ------------------------------
	task automatic stop_fail();
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			err_cnt++;
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
			stop_fail();
		end
	endtask

	// Cycles one frame may need, bus traffic included
	function automatic longint frame_cycles(input int w, input int h);
		return longint'(SU + h * (w + HS) + 10 + QUIET + 2 * (w * h + 50));
	endfunction

	// ------------------------------
	// Bus transfers, one at a time
	// ------------------------------
	task automatic bus_write(input logic [3:0] idx, input logic [31:0] data);
		@(posedge clk);
		#1;
		hsel   = 1'b1;
		htrans = TRANS_NONSEQ;
		haddr  = {26'h0, idx, 2'b00};
		hwrite = 1'b1;
		@(posedge clk);
		#1;
		hsel   = 1'b0;           // Data phase
		htrans = TRANS_IDLE;
		hwrite = 1'b0;
		hwdata = data;
	endtask

	task automatic bus_read(input logic [3:0] idx, output logic [31:0] data);
		@(posedge clk);
		#1;
		hsel   = 1'b1;
		htrans = TRANS_NONSEQ;
		haddr  = {26'h0, idx, 2'b00};
		hwrite = 1'b0;
		@(posedge clk);
		#1;
		hsel   = 1'b0;
		htrans = TRANS_IDLE;
		data   = hrdata;         // Settled from the latched index
	endtask

	task automatic set_size(input int w, input int h);
		bus_write(REG_WIDTH_HEIGHT, {16'(h), 16'(w)});
		cur_w = w;
		cur_h = h;
	endtask

	task automatic set_layer(input int act, input int bsh, input int ash);
		bus_write(REG_LAYER_CFG, {16'h0, 3'(ash), 5'(bsh), 4'h0, 1'(act), 3'h0});
		cur_act = 1'(act);
		cur_bs  = bsh;
		cur_as  = ash;
	endtask

	task automatic load_image(input logic [7:0] mask);
		bus_write(REG_IMG_ADDR, 32'h0);
		for (int i = 0; i < cur_w * cur_h; i++) begin
			img[i] = 8'($random(seed)) & mask;
			bus_write(REG_IMG_DATA, {24'h0, img[i]});   // Address auto-increments
		end
	endtask

	// Small signed weights keep the linear range busy
	task automatic draw_coefs();
		for (int k = 0; k < 4; k++) begin
			for (int t = 0; t < 9; t++)
				wt[k][t] = 8'($random(seed) % 4);
			sc[k] = 8'($random(seed) % 8);
			bi[k] = 8'($random(seed));
		end
	endtask

	task automatic load_coefs();
		for (int k = 0; k < 4; k++) begin
			for (int t = 0; t < 9; t++)
				bus_write(REG_WEIGHT, {18'h0, 2'(k), 4'(t), wt[k][t]});
			bus_write(REG_PARAM, {14'h0, 2'(k), sc[k], bi[k]});
		end
	endtask

	// Queue the whole frame, start it, then follow the done flag against the pulse count
	task automatic run_frame(input string name);
		logic [31:0] rd;
		cur_test = name;
		for (int r = 0; r < cur_h; r++) begin
			for (int c = 0; c < cur_w; c++)
				exp_q.push_back({ref_act(r, c, 3), ref_act(r, c, 2),
				                 ref_act(r, c, 1), ref_act(r, c, 0)});
		end
		pulse_cnt = 0;
		bus_write(REG_LAYER_START, 32'h1);
		bus_read(REG_LAYER_DONE, rd);
		check_val({name, " done after start"}, 32'h0, rd);
		while (exp_q.size() != 0) begin
			bus_read(REG_LAYER_DONE, rd);   // Done only once every pulse is in
			check_val({name, " done during frame"},
			          32'(pulse_cnt == cur_w * cur_h), rd);
		end
		bus_read(REG_LAYER_DONE, rd);
		check_val({name, " done at last pulse"}, 32'h1, rd);
		repeat (QUIET) @(negedge clk);    // Extra pulses get caught here
		bus_read(REG_LAYER_DONE, rd);
		check_val({name, " done at end"}, 32'h1, rd);
	endtask

	// Sum of the in-image rectangle around (r, c), all channels alike
	task automatic check_pad(input string name, input int r, input int c,
			input int r0, input int r1, input int c0, input int c1);
		int s;
		s = 0;
		for (int i = r0; i <= r1; i++) begin
			for (int j = c0; j <= c1; j++)
				s += img[i * cur_w + j];
		end
		check_val(name, {4{8'(s)}}, got_pix[r * cur_w + c]);
	endtask

	// ------------------------------
	// Output compare, mid-cycle
	// ------------------------------
	always @(negedge clk) begin
		if (rstn) begin
			check_val("bus hready", 32'h1, 32'(hready));
			check_val("bus hresp", 32'(RESP_OKAY), 32'(hresp));
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					$display("Output pixel arrived with nothing expected in %s", cur_test);
					stop_fail();
				end else begin
					exp_pix = exp_q.pop_front();
					check_val(cur_test, exp_pix, out_pixel);
					got_pix[pulse_cnt] = out_pixel;
					pulse_cnt++;
				end
			end
		end
	end

	// Watchdog
	initial begin : watchdog
		longint limit_ns;
		limit_ns = 1000;                  // Register test and reset
		for (int f = 0; f < NUM_FRAMES; f++)
			limit_ns += 2 * frame_cycles(FR_W[f], FR_H[f]) * CLK_PERIOD;
		#(limit_ns);
		$display("Run timed out after %0d ns with outputs still missing", limit_ns);
		stop_fail();
	end

	// ------------------------------
	// Tests
	// ------------------------------
	initial begin
		logic [31:0] rd;
		seed      = 32497;
		err_cnt   = 0;
		pulse_cnt = 0;
		cur_test  = "reset";
		rstn      = 1'b0;
		hsel      = 1'b0;
		hready_in = 1'b1;
		htrans    = TRANS_IDLE;
		haddr     = 32'h0;
		hwrite    = 1'b0;
		hwdata    = 32'h0;
		repeat (2) @(posedge clk);
		#1;
		rstn = 1'b1;

		// Readback in the write layouts
		cur_test = "readback";
		set_size(FR_W[0], FR_H[0]);
		bus_write(REG_DELAYS, {8'h00, 12'(HS), 12'(SU)});
		set_layer(1, 19, 5);
		bus_read(REG_WIDTH_HEIGHT, rd);
		check_val("readback dims", {16'(FR_H[0]), 16'(FR_W[0])}, rd);
		bus_read(REG_DELAYS, rd);
		check_val("readback delays", {8'h00, 12'(HS), 12'(SU)}, rd);
		bus_read(REG_LAYER_CFG, rd);
		check_val("readback cfg", {16'h0, 3'd5, 5'd19, 4'h0, 1'b1, 3'h0}, rd);

		// Centre tap only, gain k+1
		set_layer(0, 0, 0);
		load_image(8'hff);
		for (int k = 0; k < 4; k++) begin
			for (int t = 0; t < 9; t++)
				wt[k][t] = (t == 4) ? 8'(k + 1) : 8'sd0;
			sc[k] = 8'sd1;
			bi[k] = 8'sd0;
		end
		load_coefs();
		run_frame("identity");

		// All-ones kernel, small pixels so borders stay unsaturated
		set_size(FR_W[1], FR_H[1]);
		load_image(8'h1f);
		for (int k = 0; k < 4; k++) begin
			for (int t = 0; t < 9; t++)
				wt[k][t] = 8'sd1;
		end
		load_coefs();
		run_frame("zero_pad");
		check_pad("pad top left", 0, 0, 0, 1, 0, 1);
		check_pad("pad top right", 0, 5, 0, 1, 4, 5);
		check_pad("pad bottom left", 4, 0, 3, 4, 0, 1);
		check_pad("pad bottom right", 4, 5, 3, 4, 4, 5);
		check_pad("pad top edge", 0, 2, 0, 1, 1, 3);
		check_pad("pad bottom edge", 4, 3, 3, 4, 2, 4);
		check_pad("pad left edge", 2, 0, 1, 3, 0, 1);
		check_pad("pad right edge", 3, 5, 2, 4, 4, 5);

		// Random linear layer
		set_size(FR_W[2], FR_H[2]);
		set_layer(1, $random(seed) & 7, $random(seed) & 7);
		load_image(8'hff);
		draw_coefs();
		load_coefs();
		run_frame("random_layer");

		// Back-to-back frames, new size each time
		set_size(FR_W[3], FR_H[3]);
		set_layer(0, 2, 3);
		load_image(8'hff);
		draw_coefs();
		load_coefs();
		run_frame("done_first");
		set_size(FR_W[4], FR_H[4]);
		set_layer(0, 1, 2);
		load_image(8'hff);
		draw_coefs();
		load_coefs();
		run_frame("done_second");

		if (err_cnt == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			stop_fail();
		end
	end

endmodule

// File: files.f
+incdir+.
cnn_pkg.sv
cnn_ahb_regs.sv
frame_scan.sv
image_buffer.sv
conv_kernel.sv
conv_array.sv
cnn_accel.sv
tb_cnn_accel.sv

// File: Makefile
# Verilator flow for the CNN accelerator testbench

VERILATOR ?= verilator
TOP       ?= tb_cnn_accel
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_STR  ?= STATUS: PASS

SRCS := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
